// ==== hw/icache_pkg.sv ====
// Shared constants, bundles and state encodings, imported by every cache module and the testbench
`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  localparam int unsigned WaysWidth       = 2;
  localparam int unsigned NumWays         = 4;
  localparam int unsigned SetsWidth       = 6;
  // Eight 64-bit beats per line
  localparam int unsigned BeatsWidth      = 3;
  localparam int unsigned PhysAddrLen     = 32;
  localparam int unsigned LineOffsetWidth = 6;
  localparam int unsigned TagWidth        = PhysAddrLen - SetsWidth - LineOffsetWidth;
  localparam int unsigned DataWidth       = 64;
  localparam int unsigned InstrWidth      = 32;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  typedef struct packed {
    logic [TagWidth-1:0] tag;
    logic                valid;
  } tag_t;

  // A request with flush set flushes the cache first, then fetches pc
  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic        flush;
  } fetch_req_t;

  typedef struct packed {
    logic                  valid;
    logic [InstrWidth-1:0] instr;
    logic                  exception;
    logic [63:0]           tval;
  } fetch_resp_t;

  // Always a Get of one full line
  typedef struct packed {
    logic                   valid;
    logic [PhysAddrLen-1:0] address;
  } mem_a_t;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } d_opcode_e;

  typedef struct packed {
    logic                 valid;
    d_opcode_e            opcode;
    logic                 denied;
    logic [DataWidth-1:0] data;
  } mem_d_t;

  typedef struct packed {
    logic                  req;
    logic [SetsWidth-1:0]  set;
    logic [BeatsWidth-1:0] beat;
  } array_rd_t;

  typedef struct packed {
    logic                  req_tag;
    logic                  req_data;
    logic [NumWays-1:0]    ways;
    logic [SetsWidth-1:0]  set;
    logic [BeatsWidth-1:0] beat;
    tag_t                  tag;
    logic [DataWidth-1:0]  data;
  } array_wr_t;

  //////////////////////////////////////////////////////////////////////
  // State encodings
  typedef enum logic [1:0] {LockNone, LockRefill, LockAccess, LockFlush} lock_holder_e;

  typedef enum logic [1:0] {RefillIdle, RefillProgress, RefillComplete} refill_state_e;

  typedef enum logic [1:0] {FlushReset, FlushIdle, FlushDone} flush_state_e;

  typedef enum logic [2:0] {
    FetchIdle,
    FetchFetch,
    FetchReplay,
    FetchFill,
    FetchExceptionLocked,
    FetchException,
    FetchFlush
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_lock_arbiter.sv ====
// Array lock arbiter, instanced once in the cache top to serialize refill, flush and fetch access
`default_nettype none
`timescale 1ns/1ps

module icache_lock_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     refill_acq_i,
  input  logic                     flush_acq_i,
  input  logic                     access_acq_i,
  input  logic                     flush_rel_i,
  input  logic                     access_rel_i,
  input  logic                     refill_move_i,
  output icache_pkg::lock_holder_e holder_d_o,
  output icache_pkg::lock_holder_e holder_q_o
);
  import icache_pkg::*;

  logic refill_pend_q, refill_pend_d;
  logic flush_pend_q, flush_pend_d;
  logic access_pend_q, access_pend_d;

  always_comb begin
    holder_d_o    = holder_q_o;
    refill_pend_d = refill_pend_q || refill_acq_i;
    flush_pend_d  = flush_pend_q || flush_acq_i;
    access_pend_d = access_pend_q || access_acq_i;

    if (flush_rel_i || access_rel_i) begin
      holder_d_o = LockNone;
    end

    // Refill hands the lock straight to the fetch side
    if (refill_move_i) begin
      holder_d_o = LockAccess;
    end

    // Refill first since it blocks channel D
    if (holder_d_o == LockNone) begin
      if (refill_pend_d) begin
        holder_d_o    = LockRefill;
        refill_pend_d = 1'b0;
      end else if (flush_pend_d) begin
        holder_d_o   = LockFlush;
        flush_pend_d = 1'b0;
      end else if (access_pend_d) begin
        holder_d_o    = LockAccess;
        access_pend_d = 1'b0;
      end
    end
  end

  // Flush owns the arrays out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      refill_pend_q <= 1'b0;
      flush_pend_q  <= 1'b0;
      access_pend_q <= 1'b0;
      holder_q_o    <= LockFlush;
    end else begin
      refill_pend_q <= refill_pend_d;
      flush_pend_q  <= flush_pend_d;
      access_pend_q <= access_pend_d;
      holder_q_o    <= holder_d_o;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_array.sv ====
// Tag and data storage for all ways, written by the lock holder and read by the fetch FSM
`default_nettype none
`timescale 1ns/1ps

module icache_array (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  icache_pkg::lock_holder_e                                  holder_q_i,
  input  icache_pkg::array_rd_t                                     rd_i,
  input  icache_pkg::array_wr_t                                     refill_wr_i,
  input  icache_pkg::array_wr_t                                     flush_wr_i,
  input  icache_pkg::array_wr_t                                     access_wr_i,
  output icache_pkg::tag_t [icache_pkg::NumWays-1:0]                rd_tag_o,
  output logic [icache_pkg::NumWays-1:0][icache_pkg::DataWidth-1:0] rd_data_o
);
  import icache_pkg::*;

  array_wr_t            wr;
  tag_t                 tag_bypass_q;
  logic [DataWidth-1:0] data_bypass_q;

  // Writes may still land in the cycle the holder releases
  always_comb begin
    unique case (holder_q_i)
      LockRefill: wr = refill_wr_i;
      LockFlush:  wr = flush_wr_i;
      LockAccess: wr = access_wr_i;
      default:    wr = '0;
    endcase
  end

  // Bypass payload is common to all ways
  always_ff @(posedge clk_i) begin
    if (rd_i.req) begin
      tag_bypass_q  <= wr.tag;
      data_bypass_q <= wr.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Per-way memories
  for (genvar i = 0; i < NumWays; i++) begin : gen_way
    tag_t                 tag_mem  [2**SetsWidth];
    logic [DataWidth-1:0] data_mem [2**(SetsWidth+BeatsWidth)];
    tag_t                 tag_raw;
    logic [DataWidth-1:0] data_raw;
    logic                 tag_byp_q;
    logic                 data_byp_q;

    always_ff @(posedge clk_i) begin
      if (wr.req_tag && wr.ways[i]) begin
        tag_mem[wr.set] <= wr.tag;
      end
      if (wr.req_data && wr.ways[i]) begin
        data_mem[{wr.set, wr.beat}] <= wr.data;
      end
      if (rd_i.req) begin
        tag_raw  <= tag_mem[rd_i.set];
        data_raw <= data_mem[{rd_i.set, rd_i.beat}];
      end
    end

    // Same-cycle write to the read address wins over the stale memory word
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tag_byp_q  <= 1'b0;
        data_byp_q <= 1'b0;
      end else if (rd_i.req) begin
        tag_byp_q  <= wr.req_tag && wr.ways[i] && wr.set == rd_i.set;
        data_byp_q <= wr.req_data && wr.ways[i] &&
                      {wr.set, wr.beat} == {rd_i.set, rd_i.beat};
      end
    end

    assign rd_tag_o[i]  = tag_byp_q ? tag_bypass_q : tag_raw;
    assign rd_data_o[i] = data_byp_q ? data_bypass_q : data_raw;
  end

endmodule

`default_nettype wire

// ==== hw/icache_refill.sv ====
// Refill engine that drains D-channel grants into the arrays and hands the lock to the fetch FSM
`default_nettype none
`timescale 1ns/1ps

module icache_refill (
  input  logic                                                            clk_i,
  input  logic                                                            rst_ni,
  input  icache_pkg::mem_d_t                                              mem_d_i,
  output logic                                                            mem_d_ready_o,
  input  icache_pkg::lock_holder_e                                        holder_d_i,
  input  logic [icache_pkg::PhysAddrLen-icache_pkg::LineOffsetWidth-1:0] line_addr_i,
  input  logic [icache_pkg::WaysWidth-1:0]                                way_i,
  output logic                                                            acq_o,
  output logic                                                            move_o,
  output icache_pkg::array_wr_t                                           wr_o
);
  import icache_pkg::*;

  refill_state_e         state_q, state_d;
  logic [BeatsWidth-1:0] beat_q, beat_d;
  // Lock held since last cycle, so the array write mux already selects refill
  logic                  owned_q;

  always_comb begin
    mem_d_ready_o = 1'b0;
    acq_o         = 1'b0;
    move_o        = 1'b0;
    state_d       = state_q;
    beat_d        = beat_q;

    wr_o             = '0;
    wr_o.ways[way_i] = 1'b1;
    wr_o.set         = line_addr_i[SetsWidth-1:0];
    wr_o.beat        = beat_q;
    wr_o.tag.tag     = line_addr_i[PhysAddrLen-LineOffsetWidth-1:SetsWidth];
    wr_o.tag.valid   = 1'b1;
    wr_o.data        = mem_d_i.data;

    unique case (state_q)
      RefillIdle: begin
        beat_d = '0;
        if (mem_d_i.valid) begin
          if (mem_d_i.denied) begin
            // Nothing to write, drop it at once
            mem_d_ready_o = 1'b1;
          end else begin
            acq_o   = 1'b1;
            state_d = RefillProgress;
          end
        end
      end

      RefillProgress: begin
        mem_d_ready_o = owned_q && holder_d_i == LockRefill;
        if (mem_d_i.valid && mem_d_ready_o) begin
          wr_o.req_data = mem_d_i.opcode == AccessAckData;
          // Tag goes valid together with the last beat
          wr_o.req_tag  = &beat_q;
          beat_d        = beat_q + 1'b1;
          if (&beat_q) begin
            state_d = RefillComplete;
          end
        end
      end

      RefillComplete: begin
        move_o  = 1'b1;
        state_d = RefillIdle;
      end

      default: state_d = RefillIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RefillIdle;
      beat_q  <= '0;
      owned_q <= 1'b0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
      owned_q <= holder_d_i == LockRefill;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_flush.sv ====
// Flush engine that invalidates every set, run once out of reset and again on each flush request
`default_nettype none
`timescale 1ns/1ps

module icache_flush (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_req_i,
  input  icache_pkg::lock_holder_e holder_d_i,
  output logic                     acq_o,
  output logic                     rel_o,
  output logic                     done_o,
  output icache_pkg::array_wr_t    wr_o
);
  import icache_pkg::*;

  flush_state_e         state_q, state_d;
  logic [SetsWidth-1:0] set_q, set_d;

  always_comb begin
    acq_o     = 1'b0;
    rel_o     = 1'b0;
    done_o    = 1'b0;
    state_d   = state_q;
    set_d     = set_q;
    wr_o      = '0;
    wr_o.ways = '1;
    wr_o.set  = set_q;

    unique case (state_q)
      // All ways of one set per cycle, tag left invalid
      FlushReset: begin
        wr_o.req_tag = 1'b1;
        set_d        = set_q + 1'b1;
        if (&set_q) begin
          rel_o   = 1'b1;
          state_d = FlushDone;
        end
      end

      FlushIdle: begin
        if (holder_d_i == LockFlush) begin
          state_d = FlushReset;
        end
        if (flush_req_i) begin
          acq_o = 1'b1;
        end
      end

      FlushDone: begin
        done_o  = 1'b1;
        state_d = FlushIdle;
      end

      default: state_d = FlushIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FlushReset;
      set_q   <= '0;
    end else begin
      state_q <= state_d;
      set_q   <= set_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
// Fetch FSM that looks up tags, picks a victim, issues line Gets and forms the CPU response
`default_nettype none
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                                                            clk_i,
  input  logic                                                            rst_ni,
  input  icache_pkg::fetch_req_t                                          fetch_req_i,
  output icache_pkg::fetch_resp_t                                         fetch_resp_o,
  output icache_pkg::mem_a_t                                              mem_a_o,
  input  logic                                                            mem_a_ready_i,
  input  icache_pkg::mem_d_t                                              mem_d_i,
  input  logic                                                            mem_d_ready_i,
  input  icache_pkg::lock_holder_e                                        holder_d_i,
  input  icache_pkg::lock_holder_e                                        holder_q_i,
  input  icache_pkg::tag_t [icache_pkg::NumWays-1:0]                      rd_tag_i,
  input  logic [icache_pkg::NumWays-1:0][icache_pkg::DataWidth-1:0]       rd_data_i,
  input  logic                                                            refill_move_i,
  input  logic                                                            flush_done_i,
  output logic                                                            access_acq_o,
  output logic                                                            access_rel_o,
  output logic                                                            flush_req_o,
  output icache_pkg::array_rd_t                                           rd_o,
  output icache_pkg::array_wr_t                                           wr_o,
  output logic [icache_pkg::PhysAddrLen-icache_pkg::LineOffsetWidth-1:0] line_addr_o,
  output logic [icache_pkg::WaysWidth-1:0]                                way_o
);
  import icache_pkg::*;

  fetch_state_e         state_q, state_d;
  logic [63:0]          pc_q, pc_d;
  logic [WaysWidth-1:0] way_q, way_d;
  logic [WaysWidth-1:0] evict_q, evict_d;
  logic                 sent_q, sent_d;
  logic [NumWays-1:0]   hit;
  logic [WaysWidth-1:0] hit_way;
  logic [DataWidth-1:0] hit_data;
  logic                 canonical;
  logic                 rd_req;

  // Physical pc must fit below bit PhysAddrLen-1
  assign canonical = ~|fetch_req_i.pc[63:PhysAddrLen-1];
  assign hit_data  = rd_data_i[hit_way];

  //////////////////////////////////////////////////////////////////////
  // Hit detection and victim choice
  always_comb begin
    hit     = '0;
    hit_way = evict_q;
    for (int i = 0; i < NumWays; i++) begin
      hit[i] = rd_tag_i[i].valid &&
               rd_tag_i[i].tag == pc_q[PhysAddrLen-1:SetsWidth+LineOffsetWidth];
    end
    // Lowest empty way beats the eviction counter
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (!rd_tag_i[i].valid) begin
        hit_way = WaysWidth'(i);
      end
    end
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (hit[i]) begin
        hit_way = WaysWidth'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main FSM
  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    way_d   = way_q;
    evict_d = evict_q;
    sent_d  = sent_q;

    fetch_resp_o       = '0;
    fetch_resp_o.instr = pc_q[2] ? hit_data[63:32] : hit_data[31:0];
    fetch_resp_o.tval  = pc_q;

    mem_a_o         = '0;
    mem_a_o.address = {pc_q[PhysAddrLen-1:LineOffsetWidth], {LineOffsetWidth{1'b0}}};

    rd_req       = 1'b0;
    access_acq_o = 1'b0;
    access_rel_o = 1'b0;
    flush_req_o  = 1'b0;

    // Victim tag is dropped before its data gets overwritten
    wr_o               = '0;
    wr_o.ways[hit_way] = 1'b1;
    wr_o.set           = pc_q[LineOffsetWidth +: SetsWidth];
    wr_o.beat          = pc_q[3 +: BeatsWidth];

    unique case (state_q)
      FetchIdle: ;

      FetchFetch: begin
        // Always let go so refill can take the arrays
        access_rel_o = 1'b1;
        if (|hit) begin
          fetch_resp_o.valid = 1'b1;
          state_d            = FetchIdle;
        end else begin
          wr_o.req_tag = 1'b1;
          way_d        = hit_way;
          evict_d      = evict_q + 1'b1;
          sent_d       = 1'b0;
          state_d      = FetchFill;
        end
      end

      FetchReplay: begin
        rd_req = 1'b1;
        if (holder_d_i == LockAccess) begin
          state_d = FetchFetch;
        end
      end

      FetchFill: begin
        mem_a_o.valid = !sent_q;
        if (mem_a_ready_i) begin
          sent_d = 1'b1;
        end
        if (mem_d_i.valid && mem_d_ready_i && mem_d_i.denied) begin
          state_d = FetchException;
        end
        // Lock arrives with the move, read again
        if (refill_move_i) begin
          state_d = FetchReplay;
        end
      end

      FetchExceptionLocked: begin
        access_rel_o = holder_q_i == LockAccess;
        state_d      = FetchException;
      end

      FetchException: begin
        fetch_resp_o.valid     = 1'b1;
        fetch_resp_o.exception = 1'b1;
        state_d                = FetchIdle;
      end

      FetchFlush: begin
        if (flush_done_i) begin
          access_acq_o = 1'b1;
          state_d      = FetchReplay;
        end
      end

      default: state_d = FetchIdle;
    endcase

    // New request, read at once if the lock is granted this cycle
    if (fetch_req_i.valid) begin
      pc_d         = fetch_req_i.pc;
      access_acq_o = 1'b1;
      rd_req       = 1'b1;
      state_d      = holder_d_i == LockAccess ? FetchFetch : FetchReplay;
      if (fetch_req_i.flush) begin
        access_acq_o = 1'b0;
        flush_req_o  = 1'b1;
        state_d      = FetchFlush;
      end
      if (!canonical) begin
        access_acq_o = 1'b0;
        flush_req_o  = 1'b0;
        state_d      = FetchExceptionLocked;
      end
    end
  end

  assign rd_o.req     = rd_req && holder_d_i == LockAccess;
  assign rd_o.set     = pc_d[LineOffsetWidth +: SetsWidth];
  assign rd_o.beat    = pc_d[3 +: BeatsWidth];
  assign line_addr_o  = pc_q[PhysAddrLen-1:LineOffsetWidth];
  assign way_o        = way_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FetchIdle;
      evict_q <= '0;
      sent_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      evict_q <= evict_d;
      sent_q  <= sent_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_q  <= pc_d;
    way_q <= way_d;
  end

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
// Instruction cache top level, connecting CPU fetch strobes to a TileLink-style A/D memory port
`default_nettype none
`timescale 1ns/1ps

module icache_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  icache_pkg::fetch_req_t  fetch_req_i,
  output icache_pkg::fetch_resp_t fetch_resp_o,
  output icache_pkg::mem_a_t      mem_a_o,
  input  logic                    mem_a_ready_i,
  input  icache_pkg::mem_d_t      mem_d_i,
  output logic                    mem_d_ready_o
);
  import icache_pkg::*;

  lock_holder_e                       holder_d, holder_q;
  logic                               refill_acq, flush_acq, access_acq;
  logic                               flush_rel, access_rel, refill_move;
  logic                               flush_req, flush_done;
  array_rd_t                          rd;
  array_wr_t                          refill_wr, flush_wr, access_wr;
  tag_t [NumWays-1:0]                 rd_tag;
  logic [NumWays-1:0][DataWidth-1:0]  rd_data;
  logic [PhysAddrLen-LineOffsetWidth-1:0] line_addr;
  logic [WaysWidth-1:0]               way;

  icache_lock_arbiter icache_lock_arbiter_inst (
    .clk_i, .rst_ni,
    .refill_acq_i  (refill_acq),
    .flush_acq_i   (flush_acq),
    .access_acq_i  (access_acq),
    .flush_rel_i   (flush_rel),
    .access_rel_i  (access_rel),
    .refill_move_i (refill_move),
    .holder_d_o    (holder_d),
    .holder_q_o    (holder_q)
  );

  icache_array icache_array_inst (
    .clk_i, .rst_ni,
    .holder_q_i  (holder_q),
    .rd_i        (rd),
    .refill_wr_i (refill_wr),
    .flush_wr_i  (flush_wr),
    .access_wr_i (access_wr),
    .rd_tag_o    (rd_tag),
    .rd_data_o   (rd_data)
  );

  icache_refill icache_refill_inst (
    .clk_i, .rst_ni,
    .mem_d_i, .mem_d_ready_o,
    .holder_d_i  (holder_d),
    .line_addr_i (line_addr),
    .way_i       (way),
    .acq_o       (refill_acq),
    .move_o      (refill_move),
    .wr_o        (refill_wr)
  );

  icache_flush icache_flush_inst (
    .clk_i, .rst_ni,
    .flush_req_i (flush_req),
    .holder_d_i  (holder_d),
    .acq_o       (flush_acq),
    .rel_o       (flush_rel),
    .done_o      (flush_done),
    .wr_o        (flush_wr)
  );

  icache_ctrl icache_ctrl_inst (
    .clk_i, .rst_ni,
    .fetch_req_i, .fetch_resp_o,
    .mem_a_o, .mem_a_ready_i, .mem_d_i,
    .mem_d_ready_i (mem_d_ready_o),
    .holder_d_i    (holder_d),
    .holder_q_i    (holder_q),
    .rd_tag_i      (rd_tag),
    .rd_data_i     (rd_data),
    .refill_move_i (refill_move),
    .flush_done_i  (flush_done),
    .access_acq_o  (access_acq),
    .access_rel_o  (access_rel),
    .flush_req_o   (flush_req),
    .rd_o          (rd),
    .wr_o          (access_wr),
    .line_addr_o   (line_addr),
    .way_o         (way)
  );

endmodule

`default_nettype wire

// ==== tb/icache_mem_model.sv ====
// Line memory responder for the cache testbench, serving A-channel Gets with random stalls
`default_nettype none
`timescale 1ns/1ps

module icache_mem_model (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  icache_pkg::mem_a_t mem_a_i,
  output logic               mem_a_ready_o,
  output icache_pkg::mem_d_t mem_d_o,
  input  logic               mem_d_ready_i,
  output int unsigned        get_count_o
);
  import icache_pkg::*;

  logic [31:0]            lcg_q;
  logic [31:0]            lcg_next;
  logic                   busy_q;
  logic                   a_ready_q;
  mem_d_t                 d_q;
  logic [PhysAddrLen-1:0] line_q;
  logic [BeatsWidth-1:0]  beat_q;
  logic [PhysAddrLen-1:0] beat_addr;

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  assign lcg_next  = next_random(lcg_q);
  assign beat_addr = {line_q[PhysAddrLen-1:LineOffsetWidth], beat_q, 3'b000};

  // Outputs stay quiet while reset is asserted
  assign mem_a_ready_o = rst_ni && a_ready_q;
  assign mem_d_o       = rst_ni ? d_q : '0;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lcg_q       <= 32'd59716;
      busy_q      <= 1'b0;
      a_ready_q   <= 1'b0;
      d_q         <= '0;
      line_q      <= '0;
      beat_q      <= '0;
      get_count_o <= 0;
    end else begin
      lcg_q <= lcg_next;
      if (!busy_q) begin
        a_ready_q <= lcg_next[27];
        if (mem_a_i.valid && a_ready_q) begin
          busy_q      <= 1'b1;
          a_ready_q   <= 1'b0;
          line_q      <= mem_a_i.address;
          beat_q      <= '0;
          get_count_o <= get_count_o + 1;
        end
      end else if (d_q.valid) begin
        if (mem_d_ready_i) begin
          d_q.valid <= 1'b0;
          beat_q    <= beat_q + 1'b1;
          // Denied grant is a single beat
          if (d_q.denied || &beat_q) begin
            busy_q <= 1'b0;
          end
        end
      end else if (lcg_next[29]) begin
        // Upper half holds the next word, so each instruction equals its own address
        d_q.valid  <= 1'b1;
        d_q.denied <= line_q[30];
        d_q.opcode <= line_q[30] ? AccessAck : AccessAckData;
        d_q.data   <= line_q[30] ? '0 : {beat_addr + 32'd4, beat_addr};
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/icache_tb.sv ====
// Self-checking testbench for the instruction cache, built and run by the Verilator script
`default_nettype none
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  logic        clk;
  logic        rst_n;
  fetch_req_t  fetch_req;
  fetch_resp_t fetch_resp;
  mem_a_t      mem_a;
  logic        mem_a_ready;
  mem_d_t      mem_d;
  logic        mem_d_ready;
  int unsigned get_count;

  int unsigned exp_gets;
  int unsigned checks;
  int unsigned errors;
  int unsigned assert_errors;
  int unsigned tests;
  int unsigned failed_tests;
  logic        timed_out;

  // Open from the accepted Get until its last grant beat
  logic                  line_open;
  logic [BeatsWidth-1:0] beats_taken;

  icache_top icache_top_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .fetch_req_i   (fetch_req),
    .fetch_resp_o  (fetch_resp),
    .mem_a_o       (mem_a),
    .mem_a_ready_i (mem_a_ready),
    .mem_d_i       (mem_d),
    .mem_d_ready_o (mem_d_ready)
  );

  icache_mem_model icache_mem_model_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .mem_a_i       (mem_a),
    .mem_a_ready_o (mem_a_ready),
    .mem_d_o       (mem_d),
    .mem_d_ready_i (mem_d_ready),
    .get_count_o   (get_count)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Denied grant ends after one beat, a good one after eight
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_open   <= 1'b0;
      beats_taken <= '0;
    end else begin
      if (mem_a.valid && mem_a_ready) begin
        line_open   <= 1'b1;
        beats_taken <= '0;
      end else if (mem_d.valid && mem_d_ready) begin
        beats_taken <= beats_taken + 1'b1;
        if (mem_d.denied || &beats_taken) begin
          line_open <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory channel rules checked on every cycle
  a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    mem_a.valid |-> mem_a.address[LineOffsetWidth-1:0] == '0)
    else begin
      $display("error: t=%0t mem_a.address = %h, expected %h", $time, mem_a.address,
               {mem_a.address[PhysAddrLen-1:LineOffsetWidth], {LineOffsetWidth{1'b0}}});
      assert_errors = assert_errors + 1;
    end

  a_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_a.valid && !mem_a_ready |=> mem_a.valid && $stable(mem_a.address))
    else begin
      $display("t=%0t the A request dropped or changed while ready was low", $time);
      assert_errors = assert_errors + 1;
    end

  d_ready_in_grant: assert property (@(posedge clk) disable iff (!rst_n)
    mem_d_ready |-> line_open)
    else begin
      $display("t=%0t mem_d_ready was high with no line in flight", $time);
      assert_errors = assert_errors + 1;
    end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error: t=%0t %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic send_fetch(input logic [63:0] pc, input logic flush,
                            output fetch_resp_t resp);
    int unsigned cycles;
    logic        got;
    cycles = 0;
    got    = 1'b0;
    resp   = '0;
    @(posedge clk);
    fetch_req <= '{valid: 1'b1, pc: pc, flush: flush};
    @(posedge clk);
    fetch_req <= '0;
    // Room for a full flush plus a stalled refill
    while (!got && cycles < 3000) begin
      @(negedge clk);
      cycles++;
      if (fetch_resp.valid) begin
        resp = fetch_resp;
        got  = 1'b1;
      end
    end
    if (!got) begin
      $display("t=%0t timeout, no fetch response for pc %h", $time, pc);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic expect_fetch(input logic [63:0] pc, input logic flush,
                              input logic exp_exception, input logic exp_miss);
    fetch_resp_t resp;
    if (!timed_out) begin
      send_fetch(pc, flush, resp);
      if (exp_miss) begin
        exp_gets++;
      end
      if (!timed_out) begin
        check_value("fetch_resp.exception", 64'(resp.exception), 64'(exp_exception));
        if (exp_exception) begin
          check_value("fetch_resp.tval", resp.tval, pc);
        end else begin
          check_value("fetch_resp.instr", 64'(resp.instr), 64'(pc[31:0]));
        end
        check_value("get_count", 64'(get_count), 64'(exp_gets));
      end
    end
  endtask

  task automatic report_test(input string name, input logic failed);
    tests++;
    if (failed) begin
      failed_tests++;
      $display("test %0d %s: FAILED", tests, name);
    end else if (timed_out) begin
      $display("test %0d %s: not run", tests, name);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  task automatic refill_then_hit();
    int unsigned errs_before;
    errs_before = errors;
    // First fetch waits out the reset flush, then misses
    expect_fetch(64'h0000_0000_0000_1008, 1'b0, 1'b0, 1'b1);
    expect_fetch(64'h0000_0000_0000_103c, 1'b0, 1'b0, 1'b0);
    report_test("refill then hit in the same line", errors != errs_before);
  endtask

  task automatic noncanonical_fault();
    int unsigned errs_before;
    errs_before = errors;
    expect_fetch(64'h0000_0000_8000_1000, 1'b0, 1'b1, 1'b0);
    expect_fetch(64'hf000_0000_0000_1000, 1'b0, 1'b1, 1'b0);
    report_test("non-canonical pc faults without a Get", errors != errs_before);
  endtask

  task automatic denied_grant_fault();
    int unsigned errs_before;
    errs_before = errors;
    expect_fetch(64'h0000_0000_4000_2340, 1'b0, 1'b1, 1'b1);
    report_test("denied grant faults after one Get", errors != errs_before);
  endtask

  task automatic flush_then_refetch();
    int unsigned errs_before;
    errs_before = errors;
    expect_fetch(64'h0000_0000_0000_5f80, 1'b1, 1'b0, 1'b1);
    // Line of the first test was cached before the flush
    expect_fetch(64'h0000_0000_0000_1008, 1'b0, 1'b0, 1'b1);
    report_test("flush request then refetch", errors != errs_before);
  endtask

  task automatic fifo_eviction();
    logic [63:0] line_pc [5];
    int unsigned victim;
    int unsigned errs_before;
    errs_before = errors;
    // Same set with different tags
    for (int k = 0; k < 5; k++) begin
      line_pc[k] = 64'h0000_0000_0002_0a04 + 64'(k) * 64'h1000;
    end
    for (int k = 0; k < 4; k++) begin
      expect_fetch(line_pc[k], 1'b0, 1'b0, 1'b1);
    end
    // Ways fill in order and the counter steps once per miss since reset
    victim = exp_gets % NumWays;
    expect_fetch(line_pc[4], 1'b0, 1'b0, 1'b1);
    expect_fetch(line_pc[victim] + 64'h30, 1'b0, 1'b0, 1'b1);
    expect_fetch(line_pc[4] + 64'h10, 1'b0, 1'b0, 1'b0);
    report_test("pseudo-FIFO eviction in a full set", errors != errs_before);
  endtask

  initial begin
    fetch_req     = '0;
    rst_n         = 1'b0;
    exp_gets      = 0;
    checks        = 0;
    errors        = 0;
    assert_errors = 0;
    tests         = 0;
    failed_tests  = 0;
    timed_out     = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    refill_then_hit();
    noncanonical_fault();
    denied_grant_fault();
    flush_then_refetch();
    fifo_eviction();
    report_test("memory channel handshakes", assert_errors != 0);

    $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
             tests, failed_tests, checks, errors + assert_errors);
    if (failed_tests == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/icache_pkg.sv
hw/icache_lock_arbiter.sv
hw/icache_array.sv
hw/icache_refill.sv
hw/icache_flush.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tb/icache_mem_model.sv
tb/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator, exit status reports the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module icache_tb -f vlog.f -o icache_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/icache_sim) || { echo "$out"; echo "simulation aborted"; exit 1; }
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
